// ==== dv/clockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    // Release on a falling edge, like all other stimulus
    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
    end

endmodule

`default_nettype wire

// ==== dv/permTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module permTb;
    import permPkg::*;

    localparam int          PIPE_DEPTH   = 6;
    localparam int          DRAIN_CYCLES = 20;  // Watch for stray outputs at the end
    localparam logic [31:0] SEED         = 32'h46f1e08c;
    localparam string       STIM_FILE    = "dv/permutation_stimulus.txt";

    logic        clk;
    logic        resetn;
    logic        ivalid;
    logic        startNewTop;
    logic [63:0] botLower;
    logic [63:0] botUpper;
    logic        iready;
    logic        oready;
    logic        ovalid;
    resultWord_t result;
    logic        expProfile;
    logic [63:0] expValue;
    logic [31:0] expLine;
    int          errorCount;
    int          checkedCount;

    logic         isTopQ [$];
    logic [127:0] wordQ [$];
    logic [63:0]  expQ [$];
    int           lineQ [$];
    int           cycleLimit;
    int           cycleCount;
    logic [31:0]  rngState;
    int           runLeft;
    bit           stimOk;

    clockGen #(.RESET_CYCLES(3)) clkGen (.clk(clk), .resetn(resetn));

    permutationTop #(.PIPE_DEPTH(PIPE_DEPTH)) dut0 (
        .clk(clk), .resetn(resetn), .ivalid(ivalid), .startNewTop(startNewTop),
        .botLower(botLower), .botUpper(botUpper), .iready(iready),
        .oready(oready), .ovalid(ovalid), .summedDataPcoeffCountOut(result)
    );

    resultChecker #(.PIPE_DEPTH(PIPE_DEPTH)) chk0 (
        .clk(clk), .resetn(resetn), .ivalid(ivalid), .oready(oready), .ovalid(ovalid),
        .iready(iready), .result(result), .expProfile(expProfile), .expValue(expValue),
        .expLine(expLine), .errorCount(errorCount), .checkedCount(checkedCount)
    );

    function automatic logic [31:0] nextRandom(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic loadStimulus(output bit ok);
        int               fd;
        int               c;
        int               n;
        int               lineNo;
        logic [127:0]     wordVal;
        logic [8*16-1:0]  expTok;
        logic [63:0]      expVal;
        logic [8*256-1:0] rest;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("ERROR: cannot open stimulus file %s", STIM_FILE);
            ok = 1'b0;
        end else begin
            ok = 1'b1;
            lineNo = 1;
            c = $fgetc(fd);
            while (c != -1) begin
                if (c == "#") begin
                    n = $fgets(rest, fd);  // Comment runs to end of line
                    lineNo++;
                end else if (c == "\n") begin
                    lineNo++;
                end else if (c == "T" || c == "B") begin
                    n = $fscanf(fd, "%h %s", wordVal, expTok);
                    isTopQ.push_back(c == "T");
                    wordQ.push_back(wordVal);
                    lineQ.push_back(lineNo);
                    if (expTok == "P") begin
                        expQ.push_back('0);  // Profile marker
                    end else begin
                        n = $sscanf(expTok, "%h", expVal);
                        expQ.push_back(expVal);
                    end
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
        end
    endtask

    // Hold the word until it is taken on a rising edge
    task automatic driveWord(input int idx);
        @(negedge clk);
        ivalid                 = 1'b1;
        startNewTop            = isTopQ[idx];
        {botUpper, botLower}   = wordQ[idx];
        expProfile             = isTopQ[idx];
        expValue               = expQ[idx];
        expLine                = lineQ[idx];
        while (!oready) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    // Random iready with long low stretches
    always @(negedge clk) begin
        if (resetn) begin
            if (runLeft == 0) begin
                rngState = nextRandom(rngState);
                iready  <= rngState[0];
                runLeft  = rngState[0] ? 1 + int'(rngState[10:8]) : 1 + int'(rngState[20:16]);
            end else begin
                runLeft--;
            end
        end
    end

    initial begin
        cycleCount = 0;
        wait (cycleLimit > 0);
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("ERROR: timeout after %0d cycles, %0d of %0d results seen",
                 cycleCount, checkedCount, wordQ.size());
        $display("Closing: %0d errors, %0d of %0d results checked",
                 errorCount + 1, checkedCount, wordQ.size());
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        ivalid      = 1'b0;
        startNewTop = 1'b0;
        botLower    = '0;
        botUpper    = '0;
        iready      = 1'b0;
        expProfile  = 1'b0;
        expValue    = '0;
        expLine     = '0;
        rngState    = SEED;
        runLeft     = 0;
        cycleLimit  = 0;
        loadStimulus(stimOk);
        if (!stimOk) begin
            $display("Closing: %0d errors, %0d of %0d results checked",
                     errorCount + 1, checkedCount, wordQ.size());
            $display("Simulation FAILED");
            $finish;
        end else begin
            cycleLimit = 40 * wordQ.size() + 200;
            wait (resetn === 1'b1);
            for (int i = 0; i < wordQ.size(); i++) begin
                driveWord(i);
            end
            @(negedge clk);
            ivalid      = 1'b0;
            startNewTop = 1'b0;
            wait (checkedCount == wordQ.size());
            repeat (DRAIN_CYCLES) @(posedge clk);
            $display("Closing: %0d errors, %0d of %0d results checked",
                     errorCount, checkedCount, wordQ.size());
            if (errorCount == 0) begin
                $display("Simulation PASSED");
            end else begin
                $display("Simulation FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== dv/permutation_stimulus.txt ====
# kind (T top, B bot), 128-bit word as four 32-bit lanes upper first
# expected 64-bit result {count 16 bits, sum 48 bits} or P for a top profile
B 00000001000000000000000000000003 0003000000000000
B 0000FF0F000000001234567800000000 0019000000000000
T 000000FF000000FF000000FF000000FF P
B FFFFFFFF000000000000000000000000 0018000000000020
B 0F0F0F0F00FF00FFFFFF000000000001 0024000000000034
B 80000000800000008000000080000000 0004000000000000
T FFFF0000000000000000000000000000 P
B 0000FF0F000000001234567800000000 0019000000000005
B 00000001000000000000000000000003 0003000000000000
B FFFFFFFF000000000000000000000000 0010000000000010
B 0F0F0F0F00FF00FFFFFF000000000001 0029000000000020
T 000000FF000000FF000000FF000000FF P
B 80000000800000008000000080000000 0004000000000000
B 0000FF0F000000001234567800000000 0011000000000020
B 0F0F0F0F00FF00FFFFFF000000000001 0024000000000034
B 00000001000000000000000000000003 000000000000000C
T FFFF0000000000000000000000000000 P
B FFFFFFFF000000000000000000000000 0010000000000010
B 80000000800000008000000080000000 0003000000000004

// ==== dv/resultChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module resultChecker #(
    parameter int PIPE_DEPTH  = 6,
    parameter int STALL_LIMIT = 20
) (
    input  wire                  clk,
    input  wire                  resetn,
    input  wire                  ivalid,
    input  wire                  oready,
    input  wire                  ovalid,
    input  wire                  iready,
    input  permPkg::resultWord_t result,
    input  wire                  expProfile,
    input  wire [63:0]           expValue,
    input  wire [31:0]           expLine,
    output int                   errorCount,
    output int                   checkedCount
);
    import permPkg::*;

    logic            expProfQ [$];
    logic [63:0]     expValQ [$];
    int              expLineQ [$];
    int              acceptedCount;
    int              sinceProfile;  // Cycles since the last profile left
    int              stallRun;
    logic            isProf;
    logic [63:0]     want;
    int              lineNo;
    profilePayload_t prof;
    logic [63:0]     scaledActivity;
    logic [63:0]     activityBound;
    int              clockMin;
    int              clockMax;

    initial begin
        errorCount    = 0;
        checkedCount  = 0;
        acceptedCount = 0;
        sinceProfile  = 0;
        stallRun      = 0;
    end

    always @(posedge clk) begin
        if (!resetn) begin
            sinceProfile = 0;
            stallRun     = 0;
        end else begin
            sinceProfile = sinceProfile + 1;
            if (ovalid !== 1'b0 && acceptedCount == 0) begin
                errorCount++;
                $display("ERROR: output valid seen before any word was accepted");
            end
            if (ovalid === 1'b1 && iready === 1'b1) begin
                if (expValQ.size() == 0) begin
                    errorCount++;
                    $display("ERROR: output transfer with no accepted word pending");
                end else begin
                    isProf = expProfQ.pop_front();
                    want   = expValQ.pop_front();
                    lineNo = expLineQ.pop_front();
                    checkedCount++;
                    if (isProf) begin
                        prof           = result.payload;
                        scaledActivity = 64'(prof.activity) << 16;
                        activityBound  = 64'(PIPE_DEPTH) * 64'(sinceProfile);
                        clockMax       = (sinceProfile - 1) / 1024;
                        clockMin       = (sinceProfile > 1) ? (sinceProfile - 2) / 1024 : 0;
                        if (result[63:61] !== 3'b000) begin
                            errorCount++;
                            $display("mismatch top line %0d flags: expected 0, actual %0d",
                                     lineNo, result[63:61]);
                        end
                        // Clock field is the elapsed cycle count in steps of 1024
                        if (int'(prof.clocks) < clockMin || int'(prof.clocks) > clockMax) begin
                            errorCount++;
                            $display("mismatch top line %0d clocks: expected %0d to %0d, actual %0d",
                                     lineNo, clockMin, clockMax, prof.clocks);
                        end
                        // No more than PIPE_DEPTH busy stages in any elapsed cycle
                        if (scaledActivity > activityBound) begin
                            errorCount++;
                            $display("mismatch top line %0d activity: expected <= %0d, actual %0d",
                                     lineNo, activityBound, scaledActivity);
                        end
                        sinceProfile = 0;
                    end else if (result !== want) begin
                        errorCount++;
                        $display("mismatch bot line %0d: expected %h, actual %h",
                                 lineNo, want, result);
                    end
                end
            end
            if (ivalid === 1'b1 && oready === 1'b1) begin
                expProfQ.push_back(expProfile);
                expValQ.push_back(expValue);
                expLineQ.push_back(expLine);
                acceptedCount++;
            end
            // Input offered while output is blocked must soon see oready fall
            if (ivalid === 1'b1 && iready !== 1'b1) begin
                stallRun++;
            end else begin
                stallRun = 0;
            end
            if (stallRun > STALL_LIMIT && oready === 1'b1) begin
                errorCount++;
                $display("ERROR: oready still high after %0d stalled cycles", stallRun);
            end
        end
    end

endmodule

`default_nettype wire

// ==== permutationTop.f ====
verilog/permPkg.sv
verilog/inputStage.sv
verilog/topManager.sv
verilog/permutationPipeline.sv
verilog/activityProfiler.sv
verilog/resultOrderer.sv
verilog/permutationTop.sv
dv/clockGen.sv
dv/resultChecker.sv
dv/permTb.sv

// ==== verilog/activityProfiler.sv ====
`timescale 1ns/1ps
`default_nettype none

module activityProfiler #(
    parameter int PIPE_DEPTH = 6
) (
    input  wire                           clk,
    input  wire                           rst,
    input  wire [$clog2(PIPE_DEPTH+1)-1:0] activityMeasure,
    input  wire                           grabProfile,
    output permPkg::payload_t             profileWord
);
    import permPkg::*;

    logic [45:0]     activityCount;  // Sum of occupied stages per cycle
    logic [40:0]     clockCount;
    profilePayload_t profile;

    always_ff @(posedge clk) begin
        if (rst || grabProfile) begin
            activityCount <= '0;
            clockCount    <= '0;
        end else begin
            activityCount <= activityCount + 46'(activityMeasure);
            clockCount    <= clockCount + 1'b1;
        end
    end

    // Occupancy is activity / clocks / PIPE_DEPTH after rescaling by 2^6
    assign profile.activity = activityCount[45:16];
    assign profile.clocks   = clockCount[40:10];
    assign profileWord      = profile;

endmodule

`default_nettype wire

// ==== verilog/inputStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module inputStage #(
    parameter int INIT_CYCLES = 16
) (
    input  wire               clk,
    input  wire               resetn,
    input  wire               ivalid,
    input  wire               startNewTop,
    input  wire [63:0]        botLower,
    input  wire [63:0]        botUpper,
    input  wire               readyForInput,
    output logic              oready,
    output logic              rst,
    output permPkg::botWord_t word,
    output logic              writeBot,
    output logic              writeTop
);

    localparam int CNT_W = $clog2(INIT_CYCLES + 1);

    logic             botValid;
    logic             topValid;
    logic             isInitialized;
    logic [CNT_W-1:0] initCount;

    // Reset normaliser
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rst           <= 1'b1;
            isInitialized <= 1'b0;
            initCount     <= '0;
        end else begin
            rst <= 1'b0;
            if (initCount == CNT_W'(INIT_CYCLES)) begin
                isInitialized <= 1'b1;
            end else begin
                initCount <= initCount + 1'b1;
            end
        end
    end

    // One-deep holding register
    always_ff @(posedge clk) begin
        if (!resetn) begin
            botValid <= 1'b0;
            topValid <= 1'b0;
        end else if (oready) begin
            botValid <= ivalid && !startNewTop;
            topValid <= ivalid && startNewTop;
        end
    end

    always_ff @(posedge clk) begin
        if (oready) begin
            word <= {botUpper, botLower};
        end
    end

    // An empty holding slot may take a word before init completes
    assign oready   = (readyForInput && isInitialized) || (!botValid && !topValid && !rst);
    assign writeBot = botValid && oready;
    assign writeTop = topValid && oready;

    writeExclusive: assert property (@(posedge clk) disable iff (rst)
        !(writeBot && writeTop))
        else $error("writeBot and writeTop raised together");

endmodule

`default_nettype wire

// ==== verilog/permPkg.sv ====
`default_nettype none

package permPkg;

    typedef logic [127:0] botWord_t;     // One stream word, bot or top
    typedef logic [47:0]  pcoeffSum_t;
    typedef logic [12:0]  pcoeffCount_t;
    typedef logic [60:0]  payload_t;     // Result word minus the flag bits
    typedef logic [0:0]   origin_t;

    localparam origin_t ORIGIN_TOP = 1'b0;
    localparam origin_t ORIGIN_BOT = 1'b1;

    // Payload of a bot result
    typedef struct packed {
        pcoeffCount_t count;
        pcoeffSum_t   sum;
    } botPayload_t;

    // Payload of a top, scaled counter snapshots
    typedef struct packed {
        logic [29:0] activity;
        logic [30:0] clocks;
    } profilePayload_t;

    typedef struct packed {
        logic       eccFlag;
        logic [1:0] pad;
        payload_t   payload;
    } resultWord_t;

    typedef enum logic [1:0] {IDLE, DRAIN, LOAD} topState_t;

endpackage

`default_nettype wire

// ==== verilog/permutationPipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module permutationPipeline #(
    parameter int PIPE_DEPTH   = 6,
    parameter int RESULT_DEPTH = 8
) (
    input  wire                           clk,
    input  wire                           rst,
    input  permPkg::botWord_t             bot,
    input  permPkg::botWord_t             topWord,
    input  wire                           writeBot,
    input  wire                           grabResult,
    output logic                          readyForInputBot,
    output logic                          resultsAvailable,
    output permPkg::pcoeffSum_t           pcoeffSum,
    output permPkg::pcoeffCount_t         pcoeffCount,
    output logic [$clog2(PIPE_DEPTH+1)-1:0] activityMeasure
);
    import permPkg::*;

    localparam int PTR_W  = (RESULT_DEPTH > 1) ? $clog2(RESULT_DEPTH) : 1;
    localparam int FILL_W = $clog2(RESULT_DEPTH + 1);
    localparam int LOAD_W = $clog2(PIPE_DEPTH + RESULT_DEPTH + 1);
    localparam int ACT_W  = $clog2(PIPE_DEPTH + 1);

    typedef logic [7:0] laneCount_t;  // Popcount of one 128-bit word

    function automatic botWord_t rotateLanes(input botWord_t w, input int unsigned lanes);
        logic [255:0] twice;
        twice = {w, w} << (32 * lanes);
        return twice[255:128];
    endfunction

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(RESULT_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    logic [PIPE_DEPTH-1:0] stageValid;
    botWord_t              maskedRot [4];             // Stage 0
    botWord_t              outsideTop;
    laneCount_t            rotCount [4];              // Stage 1
    pcoeffCount_t          countS1;
    botPayload_t           stageData [PIPE_DEPTH-2];  // Stage 2 onward

    botPayload_t       resultBuf [RESULT_DEPTH];
    logic [PTR_W-1:0]  wrPtr;
    logic [PTR_W-1:0]  rdPtr;
    logic [FILL_W-1:0] fillCount;
    logic [LOAD_W-1:0] load;
    logic              pushResult;

    always_ff @(posedge clk) begin
        if (rst) begin
            stageValid <= '0;
        end else begin
            stageValid <= {stageValid[PIPE_DEPTH-2:0], writeBot};
        end
    end

    // Data stages run freely, validity rides in stageValid
    always_ff @(posedge clk) begin
        for (int k = 0; k < 4; k++) begin
            maskedRot[k] <= rotateLanes(bot, k) & topWord;
            rotCount[k]  <= laneCount_t'($countones(maskedRot[k]));
        end
        outsideTop         <= bot & ~topWord;
        countS1            <= pcoeffCount_t'($countones(outsideTop));
        stageData[0].count <= countS1;
        stageData[0].sum   <= pcoeffSum_t'(rotCount[0]) + pcoeffSum_t'(rotCount[1])
                            + pcoeffSum_t'(rotCount[2]) + pcoeffSum_t'(rotCount[3]);
        for (int k = 1; k < PIPE_DEPTH - 2; k++) begin
            stageData[k] <= stageData[k-1];  // Delay up to PIPE_DEPTH
        end
    end

    assign pushResult = stageValid[PIPE_DEPTH-1];

    always_ff @(posedge clk) begin
        if (pushResult) begin
            resultBuf[wrPtr] <= stageData[PIPE_DEPTH-3];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            fillCount <= '0;
        end else begin
            if (pushResult) wrPtr <= nextPtr(wrPtr);
            if (grabResult) rdPtr <= nextPtr(rdPtr);
            fillCount <= fillCount + FILL_W'(pushResult) - FILL_W'(grabResult);
        end
    end

    assign activityMeasure  = ACT_W'($countones(stageValid));
    // Every in-flight bot must find a buffer slot on exit
    assign load             = LOAD_W'(activityMeasure) + LOAD_W'(fillCount);
    assign readyForInputBot = (load < LOAD_W'(RESULT_DEPTH));
    assign resultsAvailable = (fillCount != '0);
    assign pcoeffSum        = resultBuf[rdPtr].sum;
    assign pcoeffCount      = resultBuf[rdPtr].count;

    grabNeedsResult: assert property (@(posedge clk) disable iff (rst)
        grabResult |-> resultsAvailable)
        else $error("result grabbed from an empty buffer");

endmodule

`default_nettype wire

// ==== verilog/permutationTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module permutationTop #(
    parameter int PIPE_DEPTH       = 6,
    parameter int RESULT_DEPTH     = 8,
    parameter int QUEUE_DEPTH_LOG2 = 4,
    parameter int INIT_CYCLES      = 16
) (
    input  wire                  clk,
    input  wire                  resetn,
    input  wire                  ivalid,
    input  wire                  startNewTop,
    input  wire [63:0]           botLower,
    input  wire [63:0]           botUpper,
    input  wire                  iready,
    output logic                 oready,
    output logic                 ovalid,
    output permPkg::resultWord_t summedDataPcoeffCountOut
);
    import permPkg::*;

    logic                           rst;
    logic                           readyForInput;
    logic                           pipelineReady;
    logic                           stallInput;
    logic                           writeBot;
    logic                           writeTop;
    botWord_t                       word;
    botWord_t                       topWord;
    logic                           pipelineEmpty;
    logic                           resultsAvailable;
    logic                           grabResult;
    logic                           grabProfile;
    pcoeffSum_t                     pcoeffSum;
    pcoeffCount_t                   pcoeffCount;
    payload_t                       profileWord;
    logic [$clog2(PIPE_DEPTH+1)-1:0] activityMeasure;

    assign readyForInput = pipelineReady && !stallInput;  // Hold bots back during a top change

    inputStage #(.INIT_CYCLES(INIT_CYCLES)) inStage (
        .clk(clk), .resetn(resetn), .ivalid(ivalid), .startNewTop(startNewTop),
        .botLower(botLower), .botUpper(botUpper), .readyForInput(readyForInput),
        .oready(oready), .rst(rst), .word(word), .writeBot(writeBot), .writeTop(writeTop)
    );

    topManager topMgr (
        .clk(clk), .rst(rst), .topIn(word), .writeTop(writeTop),
        .pipelineEmpty(pipelineEmpty), .stallInput(stallInput), .topWord(topWord)
    );

    permutationPipeline #(.PIPE_DEPTH(PIPE_DEPTH), .RESULT_DEPTH(RESULT_DEPTH)) evalPipe (
        .clk(clk), .rst(rst), .bot(word), .topWord(topWord), .writeBot(writeBot),
        .grabResult(grabResult), .readyForInputBot(pipelineReady),
        .resultsAvailable(resultsAvailable), .pcoeffSum(pcoeffSum),
        .pcoeffCount(pcoeffCount), .activityMeasure(activityMeasure)
    );

    activityProfiler #(.PIPE_DEPTH(PIPE_DEPTH)) profiler (
        .clk(clk), .rst(rst), .activityMeasure(activityMeasure),
        .grabProfile(grabProfile), .profileWord(profileWord)
    );

    resultOrderer #(.QUEUE_DEPTH_LOG2(QUEUE_DEPTH_LOG2)) orderer (
        .clk(clk), .rst(rst), .writeBot(writeBot), .writeTop(writeTop), .iready(iready),
        .resultsAvailable(resultsAvailable), .pcoeffSum(pcoeffSum),
        .pcoeffCount(pcoeffCount), .profileWord(profileWord), .ovalid(ovalid),
        .pipelineEmpty(pipelineEmpty), .grabResult(grabResult), .grabProfile(grabProfile),
        .result(summedDataPcoeffCountOut)
    );

endmodule

`default_nettype wire

// ==== verilog/resultOrderer.sv ====
`timescale 1ns/1ps
`default_nettype none

module resultOrderer #(
    parameter int QUEUE_DEPTH_LOG2 = 4
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   writeBot,
    input  wire                   writeTop,
    input  wire                   iready,
    input  wire                   resultsAvailable,
    input  permPkg::pcoeffSum_t   pcoeffSum,
    input  permPkg::pcoeffCount_t pcoeffCount,
    input  permPkg::payload_t     profileWord,
    output logic                  ovalid,
    output logic                  pipelineEmpty,
    output logic                  grabResult,
    output logic                  grabProfile,
    output permPkg::resultWord_t  result
);
    import permPkg::*;

    localparam int QUEUE_DEPTH = 2 ** QUEUE_DEPTH_LOG2;

    origin_t                 originMem [QUEUE_DEPTH];
    logic [QUEUE_DEPTH_LOG2:0] wrPtr;  // Extra bit tells full from empty
    logic [QUEUE_DEPTH_LOG2:0] rdPtr;
    logic                    push;
    logic                    pop;
    logic                    empty;
    logic                    full;
    origin_t                 headOrigin;
    botPayload_t             botResult;

    assign push  = writeBot || writeTop;
    assign empty = (wrPtr == rdPtr);
    assign full  = (wrPtr[QUEUE_DEPTH_LOG2] != rdPtr[QUEUE_DEPTH_LOG2])
                && (wrPtr[QUEUE_DEPTH_LOG2-1:0] == rdPtr[QUEUE_DEPTH_LOG2-1:0]);

    always_ff @(posedge clk) begin
        if (push) begin
            originMem[wrPtr[QUEUE_DEPTH_LOG2-1:0]] <= writeBot ? ORIGIN_BOT : ORIGIN_TOP;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (push) wrPtr <= wrPtr + 1'b1;
            if (pop)  rdPtr <= rdPtr + 1'b1;
        end
    end

    assign headOrigin = originMem[rdPtr[QUEUE_DEPTH_LOG2-1:0]];

    // Profile of a top is always ready
    assign ovalid        = !empty && (headOrigin == ORIGIN_TOP || resultsAvailable);
    assign pop           = ovalid && iready;
    assign grabResult    = pop && (headOrigin == ORIGIN_BOT);
    assign grabProfile   = pop && (headOrigin == ORIGIN_TOP);
    assign pipelineEmpty = empty;

    assign botResult.count = pcoeffCount;
    assign botResult.sum   = pcoeffSum;
    assign result.eccFlag  = 1'b0;
    assign result.pad      = 2'b00;
    assign result.payload  = (headOrigin == ORIGIN_BOT) ? payload_t'(botResult) : profileWord;

    noPushWhenFull: assert property (@(posedge clk) disable iff (rst)
        push |-> !full)
        else $error("origin queue overflow");

endmodule

`default_nettype wire

// ==== verilog/topManager.sv ====
`timescale 1ns/1ps
`default_nettype none

module topManager (
    input  wire               clk,
    input  wire               rst,
    input  permPkg::botWord_t topIn,
    input  wire               writeTop,
    input  wire               pipelineEmpty,
    output logic              stallInput,
    output permPkg::botWord_t topWord
);
    import permPkg::*;

    topState_t state;
    botWord_t  pendingTop;  // Waits here while older bots drain

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (writeTop) state <= DRAIN;
                DRAIN:   if (pipelineEmpty) state <= LOAD;
                LOAD:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (writeTop) begin
            pendingTop <= topIn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            topWord <= '0;
        end else if (state == LOAD) begin
            topWord <= pendingTop;  // Nothing in flight at this point
        end
    end

    assign stallInput = (state != IDLE);

    // The input side must hold a second top until the first one is loaded
    topOnlyWhenIdle: assert property (@(posedge clk) disable iff (rst)
        writeTop |-> state == IDLE)
        else $error("top written while a previous top is still pending");

endmodule

`default_nettype wire
